/* include/mem_system_defs.svh */
`ifndef MEM_SYSTEM_DEFS_SVH
`define MEM_SYSTEM_DEFS_SVH

// Word and address widths
`define MEM_ADDR_W 16
`define MEM_DATA_W 16

// Address split: tag 15..11, index 10..3, byte offset 2..0
`define MEM_TAG_W    5
`define MEM_INDEX_W  8
`define MEM_OFFSET_W 3

// Words per cache line, also the number of memory banks
`define MEM_LINE_WORDS 4

// Cycles from a memory read request to its data
`define MEM_RD_LATENCY 2

// Cycles a bank stays occupied, counting the access cycle
`define MEM_BANK_BUSY 4

`endif

/* source/mem_system_pkg.sv */
`include "mem_system_defs.svh"

package mem_system_pkg;

	// Command to both cache ways
	typedef struct packed {
		logic                     comp;     // 1 compare mode, 0 access mode
		logic                     write;
		logic [`MEM_TAG_W-1:0]    tag;
		logic [`MEM_INDEX_W-1:0]  index;
		logic [`MEM_OFFSET_W-1:0] offset;
		logic [`MEM_DATA_W-1:0]   wdata;
		logic                     valid_in; // Valid bit for access writes
	} cache_req_t;

	// Reply from one way
	typedef struct packed {
		logic                   hit;
		logic                   valid;
		logic                   dirty;
		logic [`MEM_TAG_W-1:0]  tag_out;
		logic [`MEM_DATA_W-1:0] rdata;
		logic                   err;
	} cache_rsp_t;

	typedef struct packed {
		logic                   rd;
		logic                   wr;
		logic [`MEM_ADDR_W-1:0] addr;
		logic [`MEM_DATA_W-1:0] wdata;
	} mem_req_t;

	typedef struct packed {
		logic [`MEM_DATA_W-1:0] rdata;
		logic                   err; // Bank conflict
	} mem_rsp_t;

	typedef enum logic [3:0] {
		IDLE     = 4'd0,
		COMPARE  = 4'd1,
		ENABLE   = 4'd2,
		RD0      = 4'd3,  // Write-back reads
		RD1      = 4'd4,
		RD2      = 4'd5,
		RD3      = 4'd6,
		REQ0     = 4'd7,  // Fill requests
		REQ1     = 4'd8,
		REQ2_WR0 = 4'd9,  // Requests overlapped with fill writes
		REQ3_WR1 = 4'd10,
		WR2      = 4'd11,
		WR3      = 4'd12,
		DONE     = 4'd13
	} ctrl_state_t;

endpackage

/* source/cache_way.sv */
`timescale 1ns/100ps
`include "mem_system_defs.svh"

module cache_way
	import mem_system_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       en,
	input  cache_req_t req,
	output cache_rsp_t rsp
);

	localparam int SETS   = 1 << `MEM_INDEX_W;
	localparam int WORD_W = `MEM_OFFSET_W - 1;

	logic [`MEM_TAG_W-1:0]  tag_mem  [SETS];
	logic [`MEM_DATA_W-1:0] data_mem [SETS][`MEM_LINE_WORDS];
	logic [SETS-1:0]        valid_bits;
	logic [SETS-1:0]        dirty_bits;

	logic [WORD_W-1:0] word;
	logic              tag_match;
	logic              hit;
	logic              wr_compare;
	logic              wr_access;

	assign word      = req.offset[`MEM_OFFSET_W-1:1]; // Bit 0 only flags misalignment
	assign tag_match = (tag_mem[req.index] == req.tag);
	assign hit       = en & req.comp & valid_bits[req.index] & tag_match;

	assign wr_compare = hit & req.write;        // Store on hit only
	assign wr_access  = en & ~req.comp & req.write;

	always_ff @(posedge clk) begin
		if (wr_compare | wr_access) begin
			data_mem[req.index][word] <= req.wdata;
		end
		if (wr_access) begin
			tag_mem[req.index] <= req.tag; // Fill installs the new tag
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_bits <= '0;
			dirty_bits <= '0;
		end else if (wr_access) begin
			valid_bits[req.index] <= req.valid_in;
			dirty_bits[req.index] <= 1'b0; // Line now matches memory
		end else if (wr_compare) begin
			dirty_bits[req.index] <= 1'b1;
		end
	end

	// Combinational read side
	always_comb begin
		rsp.hit     = hit;
		rsp.valid   = valid_bits[req.index];
		rsp.dirty   = dirty_bits[req.index];
		rsp.tag_out = tag_mem[req.index];
		rsp.rdata   = data_mem[req.index][word];
		rsp.err     = en & req.offset[0]; // Odd address
	end

endmodule

/* source/four_bank_mem.sv */
`timescale 1ns/100ps
`include "mem_system_defs.svh"

module four_bank_mem
	import mem_system_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  mem_req_t req,
	output mem_rsp_t rsp
);

	localparam int BANKS   = `MEM_LINE_WORDS;
	localparam int BANK_W  = $clog2(BANKS);
	localparam int ROW_W   = `MEM_ADDR_W - `MEM_OFFSET_W;
	localparam int ROWS    = 1 << ROW_W;
	localparam int LAT     = `MEM_RD_LATENCY;
	localparam int BUSY_W  = $clog2(`MEM_BANK_BUSY);

	logic [`MEM_DATA_W-1:0] bank_mem [BANKS][ROWS];
	logic [`MEM_DATA_W-1:0] rd_pipe  [LAT];
	logic [BUSY_W-1:0]      busy_cnt [BANKS];

	logic [BANK_W-1:0] bank;
	logic [ROW_W-1:0]  row;
	logic              access;

	assign bank   = req.addr[BANK_W:1];   // Word-interleaved banks
	assign row    = req.addr[`MEM_ADDR_W-1:`MEM_OFFSET_W];
	assign access = req.rd | req.wr;

	// Storage, cleared to zero on reset
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int b = 0; b < BANKS; b++) begin
				for (int r = 0; r < ROWS; r++) begin
					bank_mem[b][r] <= '0;
				end
			end
		end else if (req.wr) begin
			bank_mem[bank][row] <= req.wdata;
		end
	end

	// Read pipeline, one new read can enter every cycle
	always_ff @(posedge clk) begin
		if (req.rd) begin
			rd_pipe[0] <= bank_mem[bank][row];
		end
		for (int s = 1; s < LAT; s++) begin
			rd_pipe[s] <= rd_pipe[s-1];
		end
	end

	// Per-bank occupancy counters
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int b = 0; b < BANKS; b++) begin
				busy_cnt[b] <= '0;
			end
		end else begin
			for (int b = 0; b < BANKS; b++) begin
				if (access && (bank == BANK_W'(b))) begin
					busy_cnt[b] <= BUSY_W'(`MEM_BANK_BUSY - 1);
				end else if (busy_cnt[b] != '0) begin
					busy_cnt[b] <= busy_cnt[b] - 1'b1;
				end
			end
		end
	end

	assign rsp.rdata = rd_pipe[LAT-1];
	assign rsp.err   = access & (busy_cnt[bank] != '0); // Bank still busy

endmodule

/* source/cache_ctrl.sv */
`timescale 1ns/100ps
`include "mem_system_defs.svh"

module cache_ctrl
	import mem_system_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst,
	input  logic [`MEM_ADDR_W-1:0] addr,
	input  logic [`MEM_DATA_W-1:0] data_in,
	input  logic                   rd,
	input  logic                   wr,
	input  cache_rsp_t             way_rsp [2],
	input  mem_rsp_t               mem_rsp,
	output cache_req_t             way_req,
	output logic [1:0]             way_en,
	output mem_req_t               mem_req,
	output logic [`MEM_DATA_W-1:0] data_out,
	output logic                   done,
	output logic                   stall,
	output logic                   cache_hit,
	output logic                   err
);

	localparam int WORD_W = `MEM_OFFSET_W - 1;

	ctrl_state_t state;
	ctrl_state_t next_state;

	// Request held for the whole transaction
	logic [`MEM_ADDR_W-1:0]  req_addr;
	logic [`MEM_DATA_W-1:0]  req_data;
	logic                    req_wr;
	logic [`MEM_TAG_W-1:0]   req_tag;
	logic [`MEM_INDEX_W-1:0] req_index;

	logic victim;     // Flips after every compare
	logic chosen_way; // Way being replaced
	logic [1:0] chosen_en;
	logic pick_way;
	logic pick_dirty;
	logic any_hit;
	logic accept;
	logic data_way;
	logic [`MEM_TAG_W-1:0] victim_tag;

	// FSM decodes
	logic              comp;
	logic              cache_wr;
	logic              valid_in;
	logic              use_req_off;
	logic [WORD_W-1:0] cache_word;
	logic [WORD_W-1:0] mem_word;
	logic              data_src;  // 1 selects memory data for cache writes
	logic              tag_src;   // 1 selects victim tag for memory address
	logic              mem_rd;
	logic              mem_wr;
	logic              state_err;

	assign accept    = (state == IDLE) & (rd | wr);
	assign req_tag   = req_addr[`MEM_ADDR_W-1 -: `MEM_TAG_W];
	assign req_index = req_addr[`MEM_OFFSET_W +: `MEM_INDEX_W];
	assign any_hit   = way_rsp[0].hit | way_rsp[1].hit;
	assign chosen_en = chosen_way ? 2'b10 : 2'b01;

	// Invalid ways first, else the victim bit
	assign pick_way   = ~way_rsp[0].valid ? 1'b0 :
	                    ~way_rsp[1].valid ? 1'b1 : victim;
	assign pick_dirty = way_rsp[pick_way].valid & way_rsp[pick_way].dirty;
	assign victim_tag = way_rsp[chosen_way].tag_out;

	always_ff @(posedge clk) begin
		if (accept) begin
			req_addr <= addr;
			req_data <= data_in;
			req_wr   <= wr;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state      <= IDLE;
			victim     <= 1'b0;
			chosen_way <= 1'b0;
		end else begin
			state <= next_state;
			if (state == COMPARE) begin
				victim <= ~victim;
			end
			if (state == ENABLE) begin
				chosen_way <= pick_way;
			end
		end
	end

	always_comb begin
		next_state  = state;
		done        = 1'b0;
		cache_hit   = 1'b0;
		state_err   = 1'b0;
		way_en      = 2'b00;
		comp        = 1'b0;
		cache_wr    = 1'b0;
		valid_in    = 1'b0;
		use_req_off = 1'b0;
		cache_word  = '0;
		mem_word    = '0;
		data_src    = 1'b0;
		tag_src     = 1'b0;
		mem_rd      = 1'b0;
		mem_wr      = 1'b0;
		case (state)
			IDLE: begin
				if (accept) begin
					next_state = COMPARE;
				end
			end
			COMPARE: begin
				way_en      = 2'b11;
				comp        = 1'b1;
				cache_wr    = req_wr; // Write lands only in the hitting way
				use_req_off = 1'b1;
				if (any_hit) begin
					done       = 1'b1;
					cache_hit  = 1'b1;
					next_state = IDLE;
				end else begin
					next_state = ENABLE;
				end
			end
			ENABLE: begin
				next_state = pick_dirty ? RD0 : REQ0;
			end
			RD0, RD1, RD2, RD3: begin // Copy victim line to memory
				way_en     = chosen_en;
				cache_word = WORD_W'(state - RD0);
				mem_word   = WORD_W'(state - RD0);
				tag_src    = 1'b1;
				mem_wr     = 1'b1;
				next_state = ctrl_state_t'(state + 1'b1);
			end
			REQ0, REQ1: begin
				mem_rd     = 1'b1;
				mem_word   = WORD_W'(state - REQ0);
				next_state = ctrl_state_t'(state + 1'b1);
			end
			REQ2_WR0, REQ3_WR1: begin
				mem_rd     = 1'b1;
				mem_word   = WORD_W'(state - REQ0);
				way_en     = chosen_en;
				cache_wr   = 1'b1;
				valid_in   = 1'b1;
				data_src   = 1'b1;
				cache_word = WORD_W'(state - REQ2_WR0); // Data of the read two cycles back
				next_state = ctrl_state_t'(state + 1'b1);
			end
			WR2, WR3: begin
				way_en     = chosen_en;
				cache_wr   = 1'b1;
				valid_in   = 1'b1;
				data_src   = 1'b1;
				cache_word = WORD_W'(state - REQ2_WR0);
				next_state = ctrl_state_t'(state + 1'b1);
			end
			DONE: begin
				done        = 1'b1;
				way_en      = chosen_en;
				comp        = 1'b1;
				cache_wr    = req_wr; // Line is resident now, so this hits
				use_req_off = 1'b1;
				next_state  = IDLE;
			end
			default: begin
				state_err  = 1'b1;
				next_state = IDLE;
			end
		endcase
	end

	// Data path muxes
	always_comb begin
		way_req.comp     = comp;
		way_req.write    = cache_wr;
		way_req.tag      = req_tag;
		way_req.index    = req_index;
		way_req.offset   = use_req_off ? req_addr[`MEM_OFFSET_W-1:0] : {cache_word, 1'b0};
		way_req.wdata    = data_src ? mem_rsp.rdata : req_data;
		way_req.valid_in = valid_in;

		mem_req.rd    = mem_rd;
		mem_req.wr    = mem_wr;
		mem_req.addr  = {(tag_src ? victim_tag : req_tag), req_index, mem_word, 1'b0};
		mem_req.wdata = way_rsp[chosen_way].rdata;
	end

	assign data_way = (state == COMPARE) ? way_rsp[1].hit : chosen_way;
	assign data_out = way_rsp[data_way].rdata;
	assign stall    = (state != IDLE);

	// Misalignment shows when the ways see the request offset
	assign err = state_err | mem_rsp.err | (done & (way_rsp[0].err | way_rsp[1].err));

endmodule

/* source/mem_system.sv */
`timescale 1ns/100ps
`include "mem_system_defs.svh"

module mem_system
	import mem_system_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst,
	input  logic [`MEM_ADDR_W-1:0] addr,
	input  logic [`MEM_DATA_W-1:0] data_in,
	input  logic                   rd,
	input  logic                   wr,
	output logic [`MEM_DATA_W-1:0] data_out,
	output logic                   done,
	output logic                   stall,
	output logic                   cache_hit,
	output logic                   err
);

	cache_req_t way_req;
	logic [1:0] way_en;
	cache_rsp_t way_rsp [2];
	mem_req_t   mem_req;
	mem_rsp_t   mem_rsp;

	cache_ctrl ctrl_inst (
		.clk       (clk),
		.rst       (rst),
		.addr      (addr),
		.data_in   (data_in),
		.rd        (rd),
		.wr        (wr),
		.way_rsp   (way_rsp),
		.mem_rsp   (mem_rsp),
		.way_req   (way_req),
		.way_en    (way_en),
		.mem_req   (mem_req),
		.data_out  (data_out),
		.done      (done),
		.stall     (stall),
		.cache_hit (cache_hit),
		.err       (err)
	);

	// Both ways see the same command, enables pick the target
	cache_way way0_inst (
		.clk (clk),
		.rst (rst),
		.en  (way_en[0]),
		.req (way_req),
		.rsp (way_rsp[0])
	);

	cache_way way1_inst (
		.clk (clk),
		.rst (rst),
		.en  (way_en[1]),
		.req (way_req),
		.rsp (way_rsp[1])
	);

	four_bank_mem mem_inst (
		.clk (clk),
		.rst (rst),
		.req (mem_req),
		.rsp (mem_rsp)
	);

endmodule

/* bench/mem_system_checker.sv */
`timescale 1ns/100ps
`include "mem_system_defs.svh"

module mem_system_checker (
	input  logic                   clk,
	input  logic                   rst,
	input  logic [`MEM_ADDR_W-1:0] addr,
	input  logic [`MEM_DATA_W-1:0] data_in,
	input  logic                   rd,
	input  logic                   wr,
	input  logic [`MEM_DATA_W-1:0] data_out,
	input  logic                   done,
	input  logic                   stall,
	input  logic                   cache_hit,
	input  logic                   err,
	output int                     error_count,
	output int                     checked_count,
	output int                     hit_count
);

	localparam int WORDS     = 1 << (`MEM_ADDR_W - 1);
	localparam int SETS      = 1 << `MEM_INDEX_W;
	localparam int HIT_LAT   = 1;
	localparam int CLEAN_LAT = 9;
	localparam int DIRTY_LAT = 13; // Four write-back states added

	logic [`MEM_DATA_W-1:0] word_model [WORDS]; // Latest value of every word
	logic [`MEM_TAG_W-1:0]  tag_model [2][SETS];
	logic                   valid_model [2][SETS];
	logic                   dirty_model [2][SETS];
	logic                   victim_model;

	logic                   busy;
	int                     cycles;
	int                     exp_lat;
	logic                   exp_hit;
	logic                   exp_rd;
	logic                   exp_odd;
	logic [`MEM_DATA_W-1:0] exp_data;
	logic [`MEM_ADDR_W-1:0] cur_addr;

	task automatic report_mismatch(input string msg);
		$display("Mismatch at %0d ns: %s", $time, msg);
		error_count = error_count + 1;
	endtask

	// Runs one request through the cache model at its accepting edge
	task automatic predict(input logic [`MEM_ADDR_W-1:0] a, input logic [`MEM_DATA_W-1:0] d,
	                       input logic is_wr);
		logic [`MEM_TAG_W-1:0]   tag;
		logic [`MEM_INDEX_W-1:0] idx;
		logic [`MEM_ADDR_W-2:0]  w;
		logic                    hit0;
		logic                    hit1;
		logic                    way;
		tag  = a[`MEM_ADDR_W-1 -: `MEM_TAG_W];
		idx  = a[`MEM_OFFSET_W +: `MEM_INDEX_W];
		w    = a[`MEM_ADDR_W-1:1];
		hit0 = valid_model[0][idx] && (tag_model[0][idx] == tag);
		hit1 = valid_model[1][idx] && (tag_model[1][idx] == tag);
		victim_model = ~victim_model; // Flips on every compare
		if (hit0 || hit1) begin
			way     = hit1;
			exp_lat = HIT_LAT;
			exp_hit = 1'b1;
		end else begin
			way     = !valid_model[0][idx] ? 1'b0 : !valid_model[1][idx] ? 1'b1 : victim_model;
			exp_lat = (valid_model[way][idx] && dirty_model[way][idx]) ? DIRTY_LAT : CLEAN_LAT;
			exp_hit = 1'b0;
			tag_model[way][idx]   = tag;
			valid_model[way][idx] = 1'b1;
			dirty_model[way][idx] = 1'b0;
		end
		if (is_wr) begin
			word_model[w]         = d;
			dirty_model[way][idx] = 1'b1;
		end
		exp_data = word_model[w];
		exp_rd   = ~is_wr;
		exp_odd  = a[0];
	endtask

	// Samples the values of the cycle that just ended
	always @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < WORDS; i++) begin
				word_model[i] = '0;
			end
			for (int s = 0; s < SETS; s++) begin
				valid_model[0][s] = 1'b0;
				valid_model[1][s] = 1'b0;
			end
			victim_model  = 1'b0;
			busy          = 1'b0;
			error_count   = 0;
			checked_count = 0;
			hit_count     = 0;
		end else if (busy) begin
			cycles = cycles + 1;
			if (stall !== 1'b1) begin
				report_mismatch($sformatf("stall low in cycle %0d of addr %h", cycles, cur_addr));
			end
			if (done) begin
				checked_count = checked_count + 1;
				if (cycles != exp_lat) begin
					report_mismatch($sformatf("addr %h took %0d cycles, expected %0d",
						cur_addr, cycles, exp_lat));
				end
				if (cache_hit !== exp_hit) begin
					report_mismatch($sformatf("addr %h cache_hit %b, expected %b",
						cur_addr, cache_hit, exp_hit));
				end
				if (exp_rd && data_out !== exp_data) begin
					report_mismatch($sformatf("addr %h read %h, expected %h",
						cur_addr, data_out, exp_data));
				end
				if (err !== exp_odd) begin
					report_mismatch($sformatf("addr %h err %b, expected %b", cur_addr, err, exp_odd));
				end
				hit_count = hit_count + (cache_hit ? 1 : 0);
				busy      = 1'b0;
			end else if (err || cache_hit) begin
				report_mismatch($sformatf("err or cache_hit high before done, addr %h", cur_addr));
			end
		end else begin
			if (done || err || cache_hit) begin
				report_mismatch("done, err or cache_hit high with no request open");
			end
			if (rd || wr) begin
				if (stall) begin
					report_mismatch("stall high while idle");
				end
				predict(addr, data_in, wr);
				cur_addr = addr;
				cycles   = 0;
				busy     = 1'b1;
			end
		end
	end

endmodule

/* bench/tb_mem_system.sv */
`timescale 1ns/100ps
`include "mem_system_defs.svh"

module tb_mem_system;

	localparam int RESET_CYCLES   = 10;
	localparam int N_DIRECTED     = 9;
	localparam int N_RANDOM       = 400;
	localparam int TIMEOUT_CYCLES = (N_DIRECTED + N_RANDOM) * 14 + RESET_CYCLES + 100;
	localparam int TAG_W          = `MEM_TAG_W;
	localparam int INDEX_W        = `MEM_INDEX_W;

	logic                   clk = 1'b0;
	logic                   rst;
	logic [`MEM_ADDR_W-1:0] addr;
	logic [`MEM_DATA_W-1:0] data_in;
	logic                   rd;
	logic                   wr;
	logic [`MEM_DATA_W-1:0] data_out;
	logic                   done;
	logic                   stall;
	logic                   cache_hit;
	logic                   err;

	logic [31:0] lfsr;
	int          cycle_count = 0;
	int          issued;
	int          error_count;
	int          checked_count;
	int          hit_count;

	mem_system mem_system_inst (
		.clk       (clk),
		.rst       (rst),
		.addr      (addr),
		.data_in   (data_in),
		.rd        (rd),
		.wr        (wr),
		.data_out  (data_out),
		.done      (done),
		.stall     (stall),
		.cache_hit (cache_hit),
		.err       (err)
	);

	mem_system_checker checker_inst (
		.clk           (clk),
		.rst           (rst),
		.addr          (addr),
		.data_in       (data_in),
		.rd            (rd),
		.wr            (wr),
		.data_out      (data_out),
		.done          (done),
		.stall         (stall),
		.cache_hit     (cache_hit),
		.err           (err),
		.error_count   (error_count),
		.checked_count (checked_count),
		.hit_count     (hit_count)
	);

	always #4 clk = ~clk; // 8 ns period

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, done never came for request %0d",
				cycle_count, issued + 1);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	// Galois LFSR, taps 32 30 26 25
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
	endfunction

	task automatic draw_bits(input int n, output logic [31:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			val  = {val[30:0], lfsr[0]};
			lfsr = lfsr_step(lfsr);
		end
	endtask

	function automatic logic [`MEM_ADDR_W-1:0] make_addr(input int tag, input int index,
	                                                      input int word);
		return {TAG_W'(tag), INDEX_W'(index), 2'(word), 1'b0};
	endfunction

	// One request, held until done shows up
	task automatic issue(input logic is_wr, input logic [`MEM_ADDR_W-1:0] a,
	                     input logic [`MEM_DATA_W-1:0] d);
		@(negedge clk);
		addr    = a;
		data_in = d;
		rd      = ~is_wr;
		wr      = is_wr;
		@(negedge clk);
		rd = 1'b0;
		wr = 1'b0;
		while (!done) begin
			@(negedge clk);
		end
		issued = issued + 1;
	endtask

	initial begin
		logic [31:0] kind;
		logic [31:0] tag;
		logic [31:0] index;
		logic [31:0] word;
		logic [31:0] wdata;
		logic [31:0] odd_sel;
		logic [`MEM_ADDR_W-1:0] a;

		rst     = 1'b1;
		rd      = 1'b0;
		wr      = 1'b0;
		addr    = '0;
		data_in = '0;
		lfsr    = 32'd89771;
		issued  = 0;
		repeat (RESET_CYCLES) @(negedge clk);
		rst = 1'b0;

		issue(1'b0, make_addr(1, 5, 0), 16'h0000);         // Cold miss reads zero
		issue(1'b1, make_addr(1, 5, 0), 16'h1234);         // Write hit
		issue(1'b0, make_addr(1, 5, 0), 16'h0000);         // Read back hit
		issue(1'b1, make_addr(2, 5, 2), 16'hBEEF);         // Fills way 1
		issue(1'b0, make_addr(3, 5, 1), 16'h0000);         // Evicts dirty way 1
		issue(1'b0, make_addr(2, 5, 2), 16'h0000);         // Written back data returns
		issue(1'b0, make_addr(1, 5, 0), 16'h0000);
		issue(1'b0, make_addr(1, 5, 0) | 16'h1, 16'h0000); // Odd address on a hit
		issue(1'b1, make_addr(4, 9, 3) | 16'h1, 16'h5A5A); // Odd address on a miss

		for (int i = 0; i < N_RANDOM; i++) begin
			draw_bits(1, kind);
			draw_bits(2, tag);
			draw_bits(2, index);
			draw_bits(2, word);
			draw_bits(16, wdata);
			draw_bits(5, odd_sel);
			a = make_addr(int'(tag) * 7, int'(index) * 37 + 3, int'(word)); // Few sets, many tags
			if (odd_sel == 0) begin
				a[0] = 1'b1;
			end
			issue(kind[0], a, wdata[15:0]);
		end

		repeat (2) @(negedge clk);
		if (checked_count != issued) begin
			$display("Only %0d of %0d requests were seen finishing by the checker",
				checked_count, issued);
		end
		$display("Requests %0d, checked %0d, hits %0d, errors %0d",
			issued, checked_count, hit_count, error_count);
		if (error_count == 0 && checked_count == issued) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

/* sim.f */
+incdir+include
source/mem_system_pkg.sv
source/cache_way.sv
source/four_bank_mem.sv
source/cache_ctrl.sv
source/mem_system.sv
bench/mem_system_checker.sv
bench/tb_mem_system.sv

/* run_sim.sh */
#!/bin/bash
# Builds the testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f sim.f --top-module tb_mem_system -o tb_mem_system
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/tb_mem_system)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qF "*** TEST PASSED ***"; then
	exit 0
fi
echo "Pass message not found"
exit 1
